// ==== hdl/vga_pkg.sv ====
//********************************************************************
// VGA timing bus types
// counter width, pixel coordinate and 12-bit color shared by the
// pixel pipeline
//********************************************************************

`default_nettype none

package vga_pkg;

  // h/v counters and all sprite positions use this width
  localparam int CNT_W = 11;
  localparam int RGB_W = 12;

  typedef logic [CNT_W-1:0] cnt_t;

  // 4 bits each, red in the top nibble
  typedef logic [RGB_W-1:0] rgb_t;

endpackage

`default_nettype wire

// ==== hdl/game_pkg.sv ====
//********************************************************************
// Enemy game constants
// sprite sizes, colors, motion speeds and start position
//********************************************************************

`default_nettype none

package game_pkg;

  localparam int ENEMY_W   = 16;
  localparam int ENEMY_H   = 8;
  localparam int MISSILE_W = 2;   // player and enemy missile alike
  localparam int MISSILE_H = 4;

  localparam vga_pkg::rgb_t ENEMY_COLOR      = 12'hF00;
  localparam vga_pkg::rgb_t EN_MISSILE_COLOR = 12'hFF0;

  localparam int ENEMY_X0     = 4;
  localparam int ENEMY_Y0     = 4;
  localparam int ENEMY_STEP   = 2;  // pixels per frame, horizontal
  localparam int MISSILE_STEP = 3;  // pixels per frame, downward
  localparam int FIRE_PERIOD  = 4;  // frames between fire requests

endpackage

`default_nettype wire

// ==== hdl/vga_if.sv ====
//********************************************************************
// VGA timing bus interface
// counters, syncs, blanks and color of one pipeline stage
//********************************************************************

`default_nettype none

interface vga_if;
  import vga_pkg::*;

  cnt_t vcount;
  cnt_t hcount;
  logic vsync;
  logic hsync;
  logic vblnk;
  logic hblnk;
  rgb_t rgb;

  // driving side of a stage
  modport src (output vcount, hcount, vsync, hsync, vblnk, hblnk, rgb);

  modport snk (input vcount, hcount, vsync, hsync, vblnk, hblnk, rgb);

endinterface

`default_nettype wire

// ==== hdl/enemy_ctl.sv ====
//********************************************************************
// Enemy controller
// detects the frame start, moves the enemy left and right with a
// bounce at the screen edges and paces the fire requests
//********************************************************************

`default_nettype none

module enemy_ctl #(
  parameter int SCREEN_W = 800
) (
  input  logic          pclk,
  input  logic          rst_n_i,
  input  logic          vblnk_i,
  input  logic          alive_i,
  output logic          frame_tick_o,
  output vga_pkg::cnt_t enemy_x_o,
  output vga_pkg::cnt_t enemy_y_o,
  output logic          fire_o
);
  import vga_pkg::*;
  import game_pkg::*;

  localparam cnt_t X_MAX = cnt_t'(SCREEN_W - ENEMY_W);  // rightmost legal x
  localparam cnt_t STEP  = cnt_t'(ENEMY_STEP);
  localparam int   FC_W  = $clog2(FIRE_PERIOD + 1);
  localparam logic [FC_W-1:0] FC_LAST = FC_W'(FIRE_PERIOD - 1);

  logic            vblnk_q;
  logic            frame_edge;
  logic            dir_right_q;
  logic [FC_W-1:0] frame_cnt_q;

  assign frame_edge = vblnk_i & ~vblnk_q;  // vblnk rising
  assign enemy_y_o  = cnt_t'(ENEMY_Y0);    // enemy stays on its row

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vblnk_q      <= 1'b0;
      frame_tick_o <= 1'b0;
      fire_o       <= 1'b0;
      frame_cnt_q  <= '0;
    end else begin
      vblnk_q      <= vblnk_i;
      frame_tick_o <= frame_edge;
      fire_o       <= frame_edge && (frame_cnt_q == FC_LAST);
      if (frame_edge) begin
        frame_cnt_q <= (frame_cnt_q == FC_LAST) ? '0 : frame_cnt_q + 1'b1;
      end
    end
  end

  // position changes together with frame_tick_o
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enemy_x_o   <= cnt_t'(ENEMY_X0);
      dir_right_q <= 1'b1;
    end else if (frame_edge && alive_i) begin
      if (dir_right_q) begin
        if (enemy_x_o + STEP > X_MAX) begin
          dir_right_q <= 1'b0;  // turn instead of stepping out
        end else begin
          enemy_x_o <= enemy_x_o + STEP;
        end
      end else if (enemy_x_o < STEP) begin
        dir_right_q <= 1'b1;
      end else begin
        enemy_x_o <= enemy_x_o - STEP;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hit_detect.sv ====
//********************************************************************
// Hit detector
// tests the player missile box against the enemy box and kills the
// enemy at the next frame tick after a hit
//********************************************************************

`default_nettype none

module hit_detect (
  input  logic          pclk,
  input  logic          rst_n_i,
  input  logic          frame_tick_i,
  input  vga_pkg::cnt_t pm_x_i,
  input  vga_pkg::cnt_t pm_y_i,
  input  logic          pm_on_i,
  input  vga_pkg::cnt_t enemy_x_i,
  input  vga_pkg::cnt_t enemy_y_i,
  output logic          alive_o
);
  import vga_pkg::*;
  import game_pkg::*;

  logic overlap_x;
  logic overlap_y;
  logic hit_q;

  // boxes overlap when neither lies fully beside the other
  assign overlap_x = (pm_x_i < enemy_x_i + cnt_t'(ENEMY_W)) &&
                     (pm_x_i + cnt_t'(MISSILE_W) > enemy_x_i);
  assign overlap_y = (pm_y_i < enemy_y_i + cnt_t'(ENEMY_H)) &&
                     (pm_y_i + cnt_t'(MISSILE_H) > enemy_y_i);

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hit_q   <= 1'b0;
      alive_o <= 1'b1;
    end else begin
      if (pm_on_i && overlap_x && overlap_y && alive_o) begin
        hit_q <= 1'b1;  // sticky until reset
      end
      if (frame_tick_i && hit_q) begin
        alive_o <= 1'b0;  // only between frames
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/enemy_missile_ctl.sv ====
//********************************************************************
// Enemy missile controller
// spawns one missile below the enemy on a fire request and lets it
// fall once per frame until it leaves the screen
//********************************************************************

`default_nettype none

module enemy_missile_ctl #(
  parameter int SCREEN_H = 600
) (
  input  logic          pclk,
  input  logic          rst_n_i,
  input  logic          frame_tick_i,
  input  logic          fire_i,
  input  logic          alive_i,
  input  vga_pkg::cnt_t enemy_x_i,
  input  vga_pkg::cnt_t enemy_y_i,
  output vga_pkg::cnt_t em_x_o,
  output vga_pkg::cnt_t em_y_o,
  output logic          em_on_o
);
  import vga_pkg::*;
  import game_pkg::*;

  localparam cnt_t X_OFS  = cnt_t'((ENEMY_W - MISSILE_W) / 2);  // centered under enemy
  localparam cnt_t Y_MAX  = cnt_t'(SCREEN_H);
  localparam cnt_t M_STEP = cnt_t'(MISSILE_STEP);

  logic pend_q;
  logic fire_req;
  cnt_t em_y_next;

  // a request in the tick cycle itself counts too
  assign fire_req  = pend_q | fire_i;
  assign em_y_next = em_y_o + M_STEP;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q  <= 1'b0;
      em_on_o <= 1'b0;
    end else if (frame_tick_i) begin
      pend_q <= 1'b0;  // dropped if a missile is in flight
      if (!em_on_o) begin
        em_on_o <= fire_req && alive_i;
      end else if (em_y_next >= Y_MAX) begin
        em_on_o <= 1'b0;
      end
    end else if (fire_i) begin
      pend_q <= 1'b1;
    end
  end

  // follows the enemy while idle, then falls
  always_ff @(posedge pclk) begin
    if (frame_tick_i) begin
      if (!em_on_o) begin
        em_x_o <= enemy_x_i + X_OFS;
        em_y_o <= enemy_y_i + cnt_t'(ENEMY_H);
      end else begin
        em_y_o <= em_y_next;  // keeps falling after enemy dies
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sprite_draw.sv ====
//********************************************************************
// Sprite draw stage
// registers the timing bus and paints a solid rectangle over rgb
// inside the active area
//********************************************************************

`default_nettype none

module sprite_draw #(
  parameter int            SPR_W = 8,
  parameter int            SPR_H = 8,
  parameter vga_pkg::rgb_t COLOR = 12'hFFF
) (
  input  logic          pclk,
  input  logic          rst_n_i,
  vga_if.snk            in_bus,
  vga_if.src            out_bus,
  input  vga_pkg::cnt_t x_i,
  input  vga_pkg::cnt_t y_i,
  input  logic          on_i
);
  import vga_pkg::*;

  logic active;
  logic in_rect;

  assign active  = ~in_bus.vblnk & ~in_bus.hblnk;
  assign in_rect = (in_bus.hcount >= x_i) &&
                   (in_bus.hcount < x_i + cnt_t'(SPR_W)) &&
                   (in_bus.vcount >= y_i) &&
                   (in_bus.vcount < y_i + cnt_t'(SPR_H));

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_bus.vcount <= '0;
      out_bus.hcount <= '0;
      out_bus.vsync  <= 1'b0;
      out_bus.hsync  <= 1'b0;
      out_bus.vblnk  <= 1'b0;
      out_bus.hblnk  <= 1'b0;
      out_bus.rgb    <= '0;
    end else begin
      out_bus.vcount <= in_bus.vcount;
      out_bus.hcount <= in_bus.hcount;
      out_bus.vsync  <= in_bus.vsync;
      out_bus.hsync  <= in_bus.hsync;
      out_bus.vblnk  <= in_bus.vblnk;
      out_bus.hblnk  <= in_bus.hblnk;
      // sprite over background, never during blanking
      out_bus.rgb    <= (on_i && active && in_rect) ? COLOR : in_bus.rgb;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/enemy_unit.sv ====
//********************************************************************
// Enemy unit
// one moving enemy with hit detection and falling missiles, drawn
// over the incoming VGA stream in two pipeline stages
//********************************************************************

`default_nettype none

module enemy_unit #(
  parameter int SCREEN_W = 800,
  parameter int SCREEN_H = 600
) (
  input  logic          pclk,
  input  logic          rst_n_i,
  input  vga_pkg::cnt_t vcount_i,
  input  vga_pkg::cnt_t hcount_i,
  input  logic          vsync_i,
  input  logic          hsync_i,
  input  logic          vblnk_i,
  input  logic          hblnk_i,
  input  vga_pkg::rgb_t rgb_i,
  input  vga_pkg::cnt_t pm_x_i,   // player missile
  input  vga_pkg::cnt_t pm_y_i,
  input  logic          pm_on_i,
  output vga_pkg::cnt_t vcount_o,
  output vga_pkg::cnt_t hcount_o,
  output logic          vsync_o,
  output logic          hsync_o,
  output logic          vblnk_o,
  output logic          hblnk_o,
  output vga_pkg::rgb_t rgb_o
);
  import vga_pkg::*;
  import game_pkg::*;

  logic frame_tick;
  logic fire;
  logic alive;
  logic em_on;
  cnt_t enemy_x;
  cnt_t enemy_y;
  cnt_t em_x;
  cnt_t em_y;

  vga_if bus_in ();
  vga_if bus_mid ();  // enemy stage to missile stage
  vga_if bus_out ();

  assign bus_in.vcount = vcount_i;
  assign bus_in.hcount = hcount_i;
  assign bus_in.vsync  = vsync_i;
  assign bus_in.hsync  = hsync_i;
  assign bus_in.vblnk  = vblnk_i;
  assign bus_in.hblnk  = hblnk_i;
  assign bus_in.rgb    = rgb_i;

  enemy_ctl #(.SCREEN_W(SCREEN_W)) u_enemy_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .vblnk_i      (vblnk_i),
    .alive_i      (alive),
    .frame_tick_o (frame_tick),
    .enemy_x_o    (enemy_x),
    .enemy_y_o    (enemy_y),
    .fire_o       (fire)
  );

  hit_detect u_hit_detect (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .pm_x_i       (pm_x_i),
    .pm_y_i       (pm_y_i),
    .pm_on_i      (pm_on_i),
    .enemy_x_i    (enemy_x),
    .enemy_y_i    (enemy_y),
    .alive_o      (alive)
  );

  enemy_missile_ctl #(.SCREEN_H(SCREEN_H)) u_em_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .fire_i       (fire),
    .alive_i      (alive),
    .enemy_x_i    (enemy_x),
    .enemy_y_i    (enemy_y),
    .em_x_o       (em_x),
    .em_y_o       (em_y),
    .em_on_o      (em_on)
  );

  sprite_draw #(
    .SPR_W (ENEMY_W),
    .SPR_H (ENEMY_H),
    .COLOR (ENEMY_COLOR)
  ) draw_enemy (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .in_bus  (bus_in.snk),
    .out_bus (bus_mid.src),
    .x_i     (enemy_x),
    .y_i     (enemy_y),
    .on_i    (alive)
  );

  // missile is painted last, so it shows on top of the enemy
  sprite_draw #(
    .SPR_W (MISSILE_W),
    .SPR_H (MISSILE_H),
    .COLOR (EN_MISSILE_COLOR)
  ) draw_em (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .in_bus  (bus_mid.snk),
    .out_bus (bus_out.src),
    .x_i     (em_x),
    .y_i     (em_y),
    .on_i    (em_on)
  );

  assign vcount_o = bus_out.vcount;
  assign hcount_o = bus_out.hcount;
  assign vsync_o  = bus_out.vsync;
  assign hsync_o  = bus_out.hsync;
  assign vblnk_o  = bus_out.vblnk;
  assign hblnk_o  = bus_out.hblnk;
  assign rgb_o    = bus_out.rgb;

endmodule

`default_nettype wire

// ==== dv/enemy_unit_properties.sv ====
//********************************************************************
// Enemy unit port assertions
// bus outputs are zero in reset and follow the inputs two clocks late
//********************************************************************

`default_nettype none

module enemy_unit_props (
  input wire logic          pclk,
  input wire logic          rst_n_i,
  input wire vga_pkg::cnt_t vcount_i,
  input wire vga_pkg::cnt_t hcount_i,
  input wire logic          vsync_i,
  input wire logic          hsync_i,
  input wire logic          vblnk_i,
  input wire logic          hblnk_i,
  input wire vga_pkg::cnt_t vcount_o,
  input wire vga_pkg::cnt_t hcount_o,
  input wire logic          vsync_o,
  input wire logic          hsync_o,
  input wire logic          vblnk_o,
  input wire logic          hblnk_o,
  input wire vga_pkg::rgb_t rgb_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // held in reset for two edges, everything reads zero
  a_reset_zero: assert property (@(posedge pclk)
    (!rst_n_i && !$past(rst_n_i)) |-> (vcount_o == '0 && hcount_o == '0 && !vsync_o &&
      !hsync_o && !vblnk_o && !hblnk_o && rgb_o == '0))
    else $error("bus outputs not zero during reset");

  a_delay_cnt: assert property (@(posedge pclk) disable iff (!rst_n_i)
    ($past(rst_n_i, 2) && $past(rst_n_i)) |->
      (vcount_o == $past(vcount_i, 2) && hcount_o == $past(hcount_i, 2)))
    else $error("counters not delayed by two clocks");

  a_delay_ctl: assert property (@(posedge pclk) disable iff (!rst_n_i)
    ($past(rst_n_i, 2) && $past(rst_n_i)) |->
      ({vsync_o, hsync_o, vblnk_o, hblnk_o} ==
       $past({vsync_i, hsync_i, vblnk_i, hblnk_i}, 2)))
    else $error("syncs or blanks not delayed by two clocks");

endmodule

bind enemy_unit enemy_unit_props u_props (.*);

`default_nettype wire

// ==== dv/enemy_unit_tb.sv ====
//********************************************************************
// Enemy unit testbench
// small VGA frame generator, reference model of enemy and missile,
// and a compare process on the delayed bus
//********************************************************************

`default_nettype none

module enemy_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import vga_pkg::*;
  import game_pkg::*;

  localparam int SW    = 64;
  localparam int SH    = 48;
  localparam int H_TOT = 80;
  localparam int V_TOT = 56;
  localparam int FRAME_LIMIT = 2 * H_TOT * V_TOT;  // cycles allowed per frame

  typedef struct packed {
    cnt_t vc;
    cnt_t hc;
    logic vs;
    logic hs;
    logic vb;
    logic hb;
    rgb_t rgb;
  } pix_t;

  logic pclk = 1'b0;
  logic rst_n_i = 1'b0;
  cnt_t vcount_i = '0;
  cnt_t hcount_i = '0;
  logic vsync_i = 1'b0;
  logic hsync_i = 1'b0;
  logic vblnk_i = 1'b0;
  logic hblnk_i = 1'b0;
  rgb_t rgb_i = '0;
  cnt_t pm_x_i = '0;
  cnt_t pm_y_i = '0;
  logic pm_on_i = 1'b0;
  cnt_t vcount_o, hcount_o;
  logic vsync_o, hsync_o, vblnk_o, hblnk_o;
  rgb_t rgb_o;

  // reference model state
  int   m_ex = ENEMY_X0;
  bit   m_right = 1'b1;
  bit   m_alive = 1'b1;
  bit   m_hit = 1'b0;
  bit   m_em_on = 1'b0;
  int   m_em_x = 0;
  int   m_em_y = 0;
  int   m_ticks = 0;
  int   spawns = 0;
  int   dut_spawns = 0;
  logic em_on_q = 1'b0;
  int   fail_cnt = 0;
  int   h = 0;
  int   v = 0;
  int   rst_cnt = 0;
  pix_t exp_now = '0;
  pix_t pipe[$];

  enemy_unit #(.SCREEN_W(SW), .SCREEN_H(SH)) dut (.*);

  always #5 pclk = ~pclk;

  task automatic fail_run(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_run("output mismatch");
    end
  endtask

  function automatic rgb_t expected_rgb(input int x, input int y, input logic blank,
                                        input rgb_t bg);
    rgb_t r;
    r = bg;
    if (blank) return bg;
    if (m_alive && x >= m_ex && x < m_ex + ENEMY_W && y >= ENEMY_Y0 &&
        y < ENEMY_Y0 + ENEMY_H) r = ENEMY_COLOR;
    if (m_em_on && x >= m_em_x && x < m_em_x + MISSILE_W && y >= m_em_y &&
        y < m_em_y + MISSILE_H) r = EN_MISSILE_COLOR;  // missile on top
    return r;
  endfunction

  // state update at each vblnk rise
  task automatic frame_update();
    bit was_alive;
    bit fire;
    was_alive = m_alive;  // the kill frame still moves and may fire
    if (m_hit) m_alive = 1'b0;
    if (was_alive) begin
      if (m_right) begin
        if (m_ex + ENEMY_STEP > SW - ENEMY_W) m_right = 1'b0;
        else m_ex = m_ex + ENEMY_STEP;
      end else if (m_ex < ENEMY_STEP) m_right = 1'b1;
      else m_ex = m_ex - ENEMY_STEP;
    end
    m_ticks++;
    fire = (m_ticks % FIRE_PERIOD) == 0;
    if (!m_em_on) begin
      if (fire && was_alive) begin
        m_em_on = 1'b1;
        m_em_x = m_ex + 7;
        m_em_y = ENEMY_Y0 + ENEMY_H;
        spawns++;
      end
    end else begin
      m_em_y = m_em_y + MISSILE_STEP;
      if (m_em_y >= SH) m_em_on = 1'b0;
    end
  endtask

  // timing generator and reset release
  always @(negedge pclk) begin
    logic vb_prev;
    vb_prev = vblnk_i;
    if (rst_cnt < 10) begin
      rst_cnt++;
    end else begin
      rst_n_i  = 1'b1;
      hcount_i = cnt_t'(h);
      vcount_i = cnt_t'(v);
      hblnk_i  = (h >= SW);
      vblnk_i  = (v >= SH);
      hsync_i  = (h >= 66 && h < 72);
      vsync_i  = (v >= 50 && v < 52);
      rgb_i    = rgb_t'($urandom());
      if (vblnk_i && !vb_prev) frame_update();
      exp_now = '{cnt_t'(v), cnt_t'(h), vsync_i, hsync_i, vblnk_i, hblnk_i,
                  expected_rgb(h, v, vblnk_i | hblnk_i, rgb_i)};
      h = (h == H_TOT - 1) ? 0 : h + 1;
      if (h == 0) v = (v == V_TOT - 1) ? 0 : v + 1;
    end
  end

  always @(posedge pclk) begin
    if (rst_n_i) pipe.push_back(exp_now);
    if (pm_on_i && m_alive && pm_x_i < m_ex + ENEMY_W && pm_x_i + MISSILE_W > m_ex &&
        pm_y_i < ENEMY_Y0 + ENEMY_H && pm_y_i + MISSILE_H > ENEMY_Y0) m_hit = 1'b1;
    if (dut.em_on && !em_on_q) dut_spawns++;  // launches seen inside the DUT
    em_on_q = dut.em_on;
  end

  always @(negedge pclk) begin
    pix_t e;
    if (!rst_n_i) begin
      check("vcount_o", 32'(vcount_o), 32'h0);
      check("hcount_o", 32'(hcount_o), 32'h0);
      check("vsync_o", 32'(vsync_o), 32'h0);
      check("hsync_o", 32'(hsync_o), 32'h0);
      check("vblnk_o", 32'(vblnk_o), 32'h0);
      check("hblnk_o", 32'(hblnk_o), 32'h0);
      check("rgb_o", 32'(rgb_o), 32'h0);
    end else if (pipe.size() >= 2) begin
      e = pipe.pop_front();
      check("vcount_o", 32'(vcount_o), 32'(e.vc));
      check("hcount_o", 32'(hcount_o), 32'(e.hc));
      check("vsync_o", 32'(vsync_o), 32'(e.vs));
      check("hsync_o", 32'(hsync_o), 32'(e.hs));
      check("vblnk_o", 32'(vblnk_o), 32'(e.vb));
      check("hblnk_o", 32'(hblnk_o), 32'(e.hb));
      check("rgb_o", 32'(rgb_o), 32'(e.rgb));
    end
  end

  task automatic wait_frames(input int n);
    int start;
    int cyc;
    start = m_ticks;
    cyc = 0;
    while (m_ticks < start + n) begin
      @(negedge pclk);
      cyc++;
      if (cyc > n * FRAME_LIMIT) fail_run("frame count did not advance in time");
    end
  endtask

  task automatic wait_line(input int line);
    int cyc;
    cyc = 0;
    while (v != line) begin
      @(negedge pclk);
      cyc++;
      if (cyc > FRAME_LIMIT) fail_run("timed out waiting for an active line");
    end
  endtask

  initial begin
    int cyc;
    void'($urandom(32'h21cd));
    cyc = 0;
    while (!rst_n_i) begin
      @(negedge pclk);
      cyc++;
      if (cyc > 50) fail_run("reset was never released");
    end
    wait_frames(56);  // long enough for both edge reversals
    check("missile spawns", 32'(dut_spawns), 32'(spawns));
    wait_line(10);
    @(negedge pclk);
    pm_x_i  = cnt_t'(m_ex + 4);
    pm_y_i  = cnt_t'(ENEMY_Y0 + 2);
    pm_on_i = 1'b1;
    wait_frames(1);
    pm_on_i = 1'b0;
    wait_frames(16);
    check("alive", 32'(dut.alive), 32'h0);
    check("em_on", 32'(dut.em_on), 32'h0);
    if (fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/vga_pkg.sv
hdl/game_pkg.sv
hdl/vga_if.sv
hdl/enemy_ctl.sv
hdl/hit_detect.sv
hdl/enemy_missile_ctl.sv
hdl/sprite_draw.sv
hdl/enemy_unit.sv
dv/enemy_unit_properties.sv
dv/enemy_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the enemy unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module enemy_unit_tb -o sim_enemy_unit

out=$(./obj_dir/sim_enemy_unit)
echo "$out"

echo "$out" | grep -q "TB PASSED"
